// ==== include/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

////////////////////////////////////////
// Geometry
////////////////////////////////////////

`define IC_ADDR_W     32
`define IC_SETS       16
`define IC_SET_W      4
`define IC_WAYS       2
`define IC_WORD_W     32
`define IC_LINE_WORDS 4
`define IC_OFFSET_W   4                                   // Byte offset in a line
`define IC_TAG_W      (`IC_ADDR_W - `IC_SET_W - `IC_OFFSET_W)

////////////////////////////////////////
// AXI read burst
////////////////////////////////////////

`define IC_AXI_LEN    8'd3                                // Four beats
`define IC_AXI_SIZE   3'd2                                // 4 bytes per beat
`define IC_AXI_INCR   2'd1

`endif

// ==== design/icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

    typedef logic [`IC_ADDR_W-1:0] paddr_t;
    typedef logic [`IC_TAG_W-1:0]  ic_tag_t;
    typedef logic [`IC_SET_W-1:0]  ic_index_t;
    typedef logic [`IC_WORD_W-1:0] ic_word_t;

    // Word 0 sits in the low bits
    typedef logic [`IC_LINE_WORDS*`IC_WORD_W-1:0] ic_line_t;

    typedef logic [1:0] beat_cnt_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        RESPOND
    } refill_state_t;

endpackage

// ==== design/icache_array_if.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

interface icache_array_if
    import icache_pkg::*;
();
    // Read side, combinational from rd_index
    ic_index_t                  rd_index;
    logic [`IC_WAYS-1:0]        rd_valid;
    ic_tag_t [`IC_WAYS-1:0]     rd_tag;
    ic_line_t [`IC_WAYS-1:0]    rd_line;
    logic                       rd_lru;   // Way to evict next

    // Refill write and replacement update
    logic                       wr_en;
    logic                       wr_way;
    ic_index_t                  wr_index;
    ic_tag_t                    wr_tag;
    ic_line_t                   wr_line;
    logic                       lru_en;
    logic                       lru_way;
    logic                       flush;

    modport lookup (output rd_index, input rd_valid, rd_tag, rd_line);
    modport refill (output wr_en, wr_way, wr_index, wr_tag, wr_line, lru_en, lru_way, flush,
                    input rd_lru);
    modport storage (input rd_index, wr_en, wr_way, wr_index, wr_tag, wr_line,
                     lru_en, lru_way, flush,
                     output rd_valid, rd_tag, rd_line, rd_lru);

endinterface

// ==== design/icache_lookup_if.sv ====
`timescale 1ns/10ps

interface icache_lookup_if
    import icache_pkg::*;
();
    paddr_t   addr;       // Buffered, line aligned
    logic     hit;
    logic     hit_way;
    ic_line_t hit_line;

    modport source (
        output addr,
        output hit,
        output hit_way,
        output hit_line
    );

    modport sink (
        input addr,
        input hit,
        input hit_way,
        input hit_line
    );

endinterface

// ==== design/icache_arrays.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_arrays
    import icache_pkg::*;
(
    input logic             clk,
    input logic             rst,
    icache_array_if.storage arr
);

    logic [`IC_WAYS-1:0][`IC_SETS-1:0] valid_q;
    logic [`IC_SETS-1:0]               lru_q;
    ic_tag_t                           tag_mem [`IC_WAYS][`IC_SETS];
    ic_line_t                          data_mem [`IC_WAYS][`IC_SETS];

    ////////////////////////////////////////
    // Valid and LRU bits
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (arr.flush) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            if (arr.wr_en)
                valid_q[arr.wr_way][arr.wr_index] <= 1'b1;
            if (arr.lru_en)
                lru_q[arr.wr_index] <= ~arr.lru_way;   // Point at the other way
        end
    end

    ////////////////////////////////////////
    // Tag and data storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            tag_mem[arr.wr_way][arr.wr_index]  <= arr.wr_tag;
            data_mem[arr.wr_way][arr.wr_index] <= arr.wr_line;
        end
    end

    // Both ways read in parallel
    always_comb begin
        for (int w = 0; w < `IC_WAYS; w++) begin
            arr.rd_valid[w] = valid_q[w][arr.rd_index];
            arr.rd_tag[w]   = tag_mem[w][arr.rd_index];
            arr.rd_line[w]  = data_mem[w][arr.rd_index];
        end
    end

    assign arr.rd_lru = lru_q[arr.rd_index];

endmodule

// ==== design/icache_lookup.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_lookup
    import icache_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             accept,
    input paddr_t           req_addr,
    icache_array_if.lookup  arr,
    icache_lookup_if.source lk
);

    paddr_t              addr_q;
    ic_index_t           index;
    ic_tag_t             tag;
    logic [`IC_WAYS-1:0] way_hit;
    logic                hit_way;

    // Request buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            addr_q <= '0;
        else if (accept)
            addr_q <= {req_addr[`IC_ADDR_W-1:`IC_OFFSET_W], {`IC_OFFSET_W{1'b0}}};
    end

    assign index = addr_q[`IC_OFFSET_W +: `IC_SET_W];
    assign tag   = addr_q[`IC_ADDR_W-1 -: `IC_TAG_W];

    assign arr.rd_index = index;

    ////////////////////////////////////////
    // Tag compare
    ////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < `IC_WAYS; w++) begin
            way_hit[w] = arr.rd_valid[w] && (arr.rd_tag[w] == tag);
        end
    end

    assign hit_way = way_hit[1];   // Ways never hold the same tag

    assign lk.addr     = addr_q;
    assign lk.hit      = |way_hit;
    assign lk.hit_way  = hit_way;
    assign lk.hit_line = arr.rd_line[hit_way];

endmodule

// ==== design/icache_refill.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          req_valid,
    input  logic          flush,
    output logic          req_ready,
    output logic          accept,
    icache_lookup_if.sink lk,
    icache_array_if.refill arr,
    output logic          ar_valid,
    input  logic          ar_ready,
    output paddr_t        ar_addr,
    output logic [7:0]    ar_len,
    output logic [2:0]    ar_size,
    output logic [1:0]    ar_burst,
    input  logic          r_valid,
    input  ic_word_t      r_data,
    input  logic          r_last,
    output logic          r_ready,
    output logic          resp_load,
    input  logic          resp_done,
    output ic_line_t      refill_line
);

    refill_state_t state_q, state_d;
    logic          ready_q;
    logic          victim_q;
    beat_cnt_t     beat_q;
    ic_line_t      line_q;
    ic_line_t      fill_line;
    logic          lookup_hit;
    logic          last_beat;

    assign req_ready  = ready_q;
    assign accept     = req_valid & ready_q;
    assign lookup_hit = (state_q == LOOKUP) && lk.hit;
    assign last_beat  = (state_q == REFILL) && r_valid && r_last;

    ////////////////////////////////////////
    // Main FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (accept) state_d = LOOKUP;
            LOOKUP:  state_d = lk.hit ? RESPOND : MISS;
            MISS:    if (ar_ready) state_d = REFILL;
            REFILL:  if (last_beat) state_d = RESPOND;
            RESPOND: if (resp_done) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            ready_q  <= 1'b0;   // Rises on the first cycle out of reset
            victim_q <= 1'b0;
            beat_q   <= '0;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == IDLE);
            if (state_q == LOOKUP && !lk.hit) begin
                victim_q <= arr.rd_lru;
                beat_q   <= '0;
            end else if (state_q == REFILL && r_valid) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Beat collection
    ////////////////////////////////////////

    // Current beat merged in so the last word reaches the array directly
    always_comb begin
        fill_line = line_q;
        fill_line[beat_q*`IC_WORD_W +: `IC_WORD_W] = r_data;
    end

    always_ff @(posedge clk) begin
        if (state_q == REFILL && r_valid)
            line_q <= fill_line;
    end

    assign refill_line = fill_line;

    // AXI read channels
    assign ar_valid = (state_q == MISS);
    assign ar_addr  = lk.addr;
    assign ar_len   = `IC_AXI_LEN;
    assign ar_size  = `IC_AXI_SIZE;
    assign ar_burst = `IC_AXI_INCR;
    assign r_ready  = (state_q == REFILL);

    // Array write and LRU update
    assign arr.wr_en    = last_beat;
    assign arr.wr_way   = victim_q;
    assign arr.wr_index = lk.addr[`IC_OFFSET_W +: `IC_SET_W];
    assign arr.wr_tag   = lk.addr[`IC_ADDR_W-1 -: `IC_TAG_W];
    assign arr.wr_line  = fill_line;
    assign arr.lru_en   = lookup_hit | last_beat;
    assign arr.lru_way  = last_beat ? victim_q : lk.hit_way;
    assign arr.flush    = flush & ready_q;

    assign resp_load = lookup_hit | last_beat;

endmodule

// ==== design/icache_response.sv ====
`timescale 1ns/10ps

module icache_response
    import icache_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          resp_load,
    output logic          resp_done,
    icache_lookup_if.sink lk,
    input  ic_line_t      refill_line,
    output logic          resp_valid,
    input  logic          resp_ready,
    output paddr_t        resp_addr,
    output ic_line_t      resp_data
);

    logic     valid_q;
    paddr_t   addr_q;
    ic_line_t data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= 1'b0;
        else if (resp_load)
            valid_q <= 1'b1;
        else if (resp_done)
            valid_q <= 1'b0;
    end

    // Held until the handshake
    always_ff @(posedge clk) begin
        if (resp_load) begin
            addr_q <= lk.addr;
            data_q <= lk.hit ? lk.hit_line : refill_line;
        end
    end

    assign resp_done  = valid_q & resp_ready;
    assign resp_valid = valid_q;
    assign resp_addr  = addr_q;
    assign resp_data  = data_q;

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/10ps

module icache_top
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // Fetch request
    input  logic       req_valid,
    output logic       req_ready,
    input  paddr_t     req_addr,
    // Response
    output logic       resp_valid,
    input  logic       resp_ready,
    output paddr_t     resp_addr,
    output ic_line_t   resp_data,
    input  logic       flush,
    // AXI read
    output logic       ar_valid,
    input  logic       ar_ready,
    output paddr_t     ar_addr,
    output logic [7:0] ar_len,
    output logic [2:0] ar_size,
    output logic [1:0] ar_burst,
    input  logic       r_valid,
    input  ic_word_t   r_data,
    input  logic       r_last,
    output logic       r_ready
);

    logic     accept;
    logic     resp_load;
    logic     resp_done;
    ic_line_t refill_line;

    icache_array_if  arr_if ();
    icache_lookup_if lk_if ();

    icache_arrays u_arrays (
        .clk (clk),
        .rst (rst),
        .arr (arr_if.storage)
    );

    icache_lookup u_lookup (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .req_addr (req_addr),
        .arr      (arr_if.lookup),
        .lk       (lk_if.source)
    );

    icache_refill u_refill (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .flush       (flush),
        .req_ready   (req_ready),
        .accept      (accept),
        .lk          (lk_if.sink),
        .arr         (arr_if.refill),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar_addr     (ar_addr),
        .ar_len      (ar_len),
        .ar_size     (ar_size),
        .ar_burst    (ar_burst),
        .r_valid     (r_valid),
        .r_data      (r_data),
        .r_last      (r_last),
        .r_ready     (r_ready),
        .resp_load   (resp_load),
        .resp_done   (resp_done),
        .refill_line (refill_line)
    );

    icache_response u_response (
        .clk         (clk),
        .rst         (rst),
        .resp_load   (resp_load),
        .resp_done   (resp_done),
        .lk          (lk_if.sink),
        .refill_line (refill_line),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_addr   (resp_addr),
        .resp_data   (resp_data)
    );

endmodule

// ==== tb/icache_asserts.sv ====
`timescale 1ns/10ps

module icache_asserts
    import icache_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     req_ready,
    input logic     ar_valid,
    input logic     ar_ready,
    input paddr_t   ar_addr,
    input logic     resp_valid,
    input logic     resp_ready,
    input paddr_t   resp_addr,
    input ic_line_t resp_data
);

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_valid dropped or ar_addr changed before ar_ready");

    // Response must not move while stalled
    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_addr))
        else $error("response changed before resp_ready");

    reset_quiet: assert property (@(posedge clk) rst |-> !req_ready && !ar_valid)
        else $error("req_ready or ar_valid high during reset");

endmodule

bind icache_top icache_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .req_ready  (req_ready),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_addr    (ar_addr),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_addr  (resp_addr),
    .resp_data  (resp_data)
);

// ==== tb/icache_tb.sv ====
`timescale 1ns/10ps
`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
();

    typedef struct packed {
        paddr_t     addr;
        logic       miss;        // Expected outcome
        logic [3:0] ready_dly;   // Cycles of resp_ready low
        logic       flush;       // Flush pulse before the fetch
    } fetch_t;

    localparam int N_ENTRIES      = 11;
    localparam int TIMEOUT_CYCLES = 16 + 40 * N_ENTRIES;

    fetch_t tbl [N_ENTRIES] = '{
        '{32'h0000_1030, 1'b1, 4'd0, 1'b0},   // A
        '{32'h0000_103C, 1'b0, 4'd0, 1'b0},
        '{32'h0000_2030, 1'b1, 4'd0, 1'b0},   // B
        '{32'h0000_1034, 1'b0, 4'd2, 1'b0},
        '{32'h0000_3030, 1'b1, 4'd0, 1'b0},   // C evicts B
        '{32'h0000_1030, 1'b0, 4'd0, 1'b0},
        '{32'h0000_2038, 1'b1, 4'd0, 1'b0},
        '{32'h8000_0F40, 1'b1, 4'd6, 1'b0},
        '{32'h8000_0F40, 1'b0, 4'd4, 1'b0},
        '{32'h0000_1030, 1'b1, 4'd0, 1'b1},
        '{32'h8000_0F4C, 1'b1, 4'd0, 1'b0}
    };

    logic       clk, rst, req_valid, req_ready, resp_valid, resp_ready, flush;
    paddr_t     req_addr, resp_addr, ar_addr;
    ic_line_t   resp_data;
    logic       ar_valid, ar_ready, r_valid, r_last, r_ready;
    logic [7:0] ar_len;
    logic [2:0] ar_size;
    logic [1:0] ar_burst;
    ic_word_t   r_data;

    logic [31:0] lcg_state = 32'd66;
    int          errors = 0;
    int          cycle_cnt = 0;
    int          ar_count = 0;
    paddr_t      seen_addr;
    logic [7:0]  seen_len;
    logic [2:0]  seen_size;
    logic [1:0]  seen_burst;

    // Reference model of tags and replacement
    ic_tag_t model_tag [`IC_SETS][`IC_WAYS];
    logic    model_valid [`IC_SETS][`IC_WAYS];
    logic    model_lru [`IC_SETS];

    icache_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [1:0] next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[17:16];
    endfunction

    task automatic expect_equal(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < `IC_SETS; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < `IC_WAYS; w++)
                model_valid[s][w] = 1'b0;
        end
    endtask

    function automatic logic predict_miss(input paddr_t a);
        ic_index_t idx = a[`IC_OFFSET_W +: `IC_SET_W];
        ic_tag_t   tg  = a[`IC_ADDR_W-1 -: `IC_TAG_W];
        logic      victim;
        for (int w = 0; w < `IC_WAYS; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tg) begin
                model_lru[idx] = (w == 0);   // Evict the other way next
                return 1'b0;
            end
        end
        victim = model_lru[idx];
        model_valid[idx][victim] = 1'b1;
        model_tag[idx][victim]   = tg;
        model_lru[idx]           = ~victim;
        return 1'b1;
    endfunction

    ////////////////////////////////////////
    // AXI memory model
    ////////////////////////////////////////

    initial begin : axi_memory
        paddr_t base;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_last   = 1'b0;
        forever begin
            next_cycle();
            if (ar_valid) begin
                base       = ar_addr;
                seen_addr  = ar_addr;
                seen_len   = ar_len;
                seen_size  = ar_size;
                seen_burst = ar_burst;
                repeat (next_delay()) next_cycle();
                ar_ready = 1'b1;
                next_cycle();
                ar_ready = 1'b0;
                ar_count++;
                for (int b = 0; b < `IC_LINE_WORDS; b++) begin
                    repeat (next_delay()) next_cycle();
                    r_valid = 1'b1;
                    r_data  = (base + 32'(4 * b)) ^ 32'hA5A5_0000;
                    r_last  = (b == `IC_LINE_WORDS - 1);
                    expect_equal("r_ready", 128'(r_ready), 128'(1));
                    next_cycle();
                    r_valid = 1'b0;
                    r_last  = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles waiting for the DUT", cycle_cnt);
                $display("tests failed");
                $fatal(1, "timeout");
            end
        end
    end

    ////////////////////////////////////////
    // One table entry
    ////////////////////////////////////////

    task automatic run_fetch(input int idx);
        fetch_t   e;
        paddr_t   line_addr;
        ic_line_t exp_line;
        ic_line_t held;
        logic     exp_miss;
        int       lat;
        int       ar_before;
        e         = tbl[idx];
        line_addr = {e.addr[`IC_ADDR_W-1:`IC_OFFSET_W], {`IC_OFFSET_W{1'b0}}};
        for (int i = 0; i < `IC_LINE_WORDS; i++)
            exp_line[i*32 +: 32] = (line_addr + 32'(4 * i)) ^ 32'hA5A5_0000;

        if (e.flush) begin
            expect_equal("req_ready before flush", 128'(req_ready), 128'(1));
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
            clear_model();
        end
        exp_miss = predict_miss(e.addr);
        expect_equal("model miss vs table", 128'(exp_miss), 128'(e.miss));

        ar_before = ar_count;
        req_addr  = e.addr;
        req_valid = 1'b1;
        while (!req_ready) next_cycle();
        next_cycle();                        // Acceptance edge
        req_valid = 1'b0;
        expect_equal("req_ready", 128'(req_ready), 128'(0));

        lat = 0;
        while (!resp_valid) begin
            next_cycle();
            lat++;
        end
        expect_equal("miss count", 128'(ar_count - ar_before), 128'(exp_miss));
        if (exp_miss) begin
            expect_equal("ar_addr", 128'(seen_addr), 128'(line_addr));
            expect_equal("ar_len", 128'(seen_len), 128'(3));
            expect_equal("ar_size", 128'(seen_size), 128'(2));
            expect_equal("ar_burst", 128'(seen_burst), 128'(1));
        end else begin
            expect_equal("hit latency", 128'(lat), 128'(1));
        end
        expect_equal("resp_addr", 128'(resp_addr), 128'(line_addr));
        expect_equal("resp_data", resp_data, exp_line);

        held = resp_data;
        repeat (e.ready_dly) begin
            next_cycle();
            expect_equal("resp_valid", 128'(resp_valid), 128'(1));
            expect_equal("resp_data held", resp_data, held);
            expect_equal("req_ready", 128'(req_ready), 128'(0));
        end
        resp_ready = 1'b1;
        next_cycle();
        resp_ready = 1'b0;
        expect_equal("resp_valid after handshake", 128'(resp_valid), 128'(0));
        expect_equal("req_ready after handshake", 128'(req_ready), 128'(1));
    endtask

    initial begin : main
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        resp_ready = 1'b0;
        flush      = 1'b0;
        clear_model();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < N_ENTRIES; i++)
            run_fetch(i);

        if (errors == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== icache_top.f ====
+incdir+include
design/icache_pkg.sv
design/icache_array_if.sv
design/icache_lookup_if.sv
design/icache_arrays.sv
design/icache_lookup.sv
design/icache_refill.sv
design/icache_response.sv
design/icache_top.sv
tb/icache_asserts.sv
tb/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module icache_tb -f icache_top.f -o icache_sim

status=0
./obj_dir/icache_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "tests failed" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished cleanly"
